//--- common/exePkg.sv
package exePkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;

    // ALU select codes
    localparam logic [3:0] AluAdd = 4'd0;
    localparam logic [3:0] AluSub = 4'd1;
    localparam logic [3:0] AluAnd = 4'd2;
    localparam logic [3:0] AluOr  = 4'd3;
    localparam logic [3:0] AluXor = 4'd4;
    localparam logic [3:0] AluNor = 4'd5;
    localparam logic [3:0] AluSlt = 4'd6;
    localparam logic [3:0] AluSll = 4'd7;
    localparam logic [3:0] AluSrl = 4'd8;
    localparam logic [3:0] AluSra = 4'd9;
    localparam logic [3:0] AluLui = 4'd10;

    // ALU op from the main decoder
    localparam logic [1:0] AluOpAdd   = 2'b00;   // loads and stores
    localparam logic [1:0] AluOpSub   = 2'b01;   // branches
    localparam logic [1:0] AluOpFunct = 2'b10;
    localparam logic [1:0] AluOpImm   = 2'b11;

    // R-type funct field
    localparam logic [5:0] FunctAdd = 6'h20;
    localparam logic [5:0] FunctSub = 6'h22;
    localparam logic [5:0] FunctAnd = 6'h24;
    localparam logic [5:0] FunctOr  = 6'h25;
    localparam logic [5:0] FunctXor = 6'h26;
    localparam logic [5:0] FunctNor = 6'h27;
    localparam logic [5:0] FunctSlt = 6'h2a;
    localparam logic [5:0] FunctSll = 6'h00;
    localparam logic [5:0] FunctSrl = 6'h02;
    localparam logic [5:0] FunctSra = 6'h03;

    // I-type opcodes
    localparam logic [5:0] OpAddi = 6'h08;
    localparam logic [5:0] OpSlti = 6'h0a;
    localparam logic [5:0] OpAndi = 6'h0c;
    localparam logic [5:0] OpOri  = 6'h0d;
    localparam logic [5:0] OpXori = 6'h0e;
    localparam logic [5:0] OpLui  = 6'h0f;

    // Operand source select from the forwarding unit
    localparam logic [1:0] FwdReg = 2'b00;
    localparam logic [1:0] FwdWb  = 2'b01;
    localparam logic [1:0] FwdMem = 2'b10;

    ////////////////////////////////////////////////////////////
    // Control and pipeline bundles
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic regWrite;
        logic memToReg;
    } wbCtrl_t;

    typedef struct packed {
        logic branch;
        logic memRead;
        logic memWrite;
    } memCtrl_t;

    typedef struct packed {
        logic       regDst;
        logic [1:0] aluOp;
        logic       aluSrc;
    } exeCtrl_t;

    typedef struct packed {
        wbCtrl_t  wb;
        memCtrl_t mem;
        exeCtrl_t exe;
    } idExCtrl_t;

    typedef struct packed {
        logic [RegAddrWidth-1:0] rd;
        logic                    regWrite;
        logic [DataWidth-1:0]    data;
    } fwdSrc_t;

    typedef struct packed {
        wbCtrl_t                 wb;
        memCtrl_t                mem;
        logic [DataWidth-1:0]    aluResult;
        logic                    zero;
        logic [DataWidth-1:0]    storeData;
        logic [RegAddrWidth-1:0] writeReg;
    } exMem_t;

    // Low half of the instruction, sign extended, seen as R-type fields
    typedef struct packed {
        logic [15:0]             upper;
        logic [RegAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rFields_t;

    typedef union packed {
        logic signed [DataWidth-1:0] imm;
        rFields_t                    r;
    } instrWord_t;

endpackage

//--- rtl/alu.sv
`timescale 1ns/10ps

module alu
    import exePkg::*;
(
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  logic [3:0]           aluSel,
    output logic [DataWidth-1:0] result,
    output logic                 zero
);

    logic [4:0] shamt;

    // Shift distance comes from the low bits only
    assign shamt = b[4:0];

    always_comb
    begin
        case (aluSel)
            AluAdd:
                result = a + b;
            AluSub:
                result = a - b;
            AluAnd:
                result = a & b;
            AluOr:
                result = a | b;
            AluXor:
                result = a ^ b;
            AluNor:
                result = ~(a | b);
            AluSlt:
                // Signed compare
                result = {{(DataWidth-1){1'b0}}, ($signed(a) < $signed(b))};
            AluSll:
                result = a << shamt;
            AluSrl:
                result = a >> shamt;
            AluSra:
                result = $signed(a) >>> shamt;
            AluLui:
                result = {b[15:0], 16'b0};
            default:
                result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- rtl/aluControl.sv
`timescale 1ns/10ps

module aluControl
    import exePkg::*;
(
    input  logic [1:0] aluOp,
    input  logic [5:0] funct,
    input  logic [5:0] immOpcode,
    output logic [3:0] aluSel,
    output logic       shiftOp
);

    logic [3:0] functSel;
    logic [3:0] immSel;

    // R-type decode
    always_comb
    begin
        case (funct)
            FunctAdd: functSel = AluAdd;
            FunctSub: functSel = AluSub;
            FunctAnd: functSel = AluAnd;
            FunctOr:  functSel = AluOr;
            FunctXor: functSel = AluXor;
            FunctNor: functSel = AluNor;
            FunctSlt: functSel = AluSlt;
            FunctSll: functSel = AluSll;
            FunctSrl: functSel = AluSrl;
            FunctSra: functSel = AluSra;
            default:  functSel = AluAdd;
        endcase
    end

    // I-type arithmetic decode
    always_comb
    begin
        case (immOpcode)
            OpAddi:  immSel = AluAdd;
            OpSlti:  immSel = AluSlt;
            OpAndi:  immSel = AluAnd;
            OpOri:   immSel = AluOr;
            OpXori:  immSel = AluXor;
            OpLui:   immSel = AluLui;
            default: immSel = AluAdd;
        endcase
    end

    always_comb
    begin
        case (aluOp)
            AluOpAdd:   aluSel = AluAdd;
            AluOpSub:   aluSel = AluSub;
            AluOpFunct: aluSel = functSel;
            AluOpImm:   aluSel = immSel;
            default:    aluSel = AluAdd;
        endcase
    end

    // Shift by shamt takes rt as the shifted value
    assign shiftOp = (aluOp == AluOpFunct)
                  && (funct == FunctSll || funct == FunctSrl || funct == FunctSra);

endmodule

//--- rtl/forwardingUnit.sv
`timescale 1ns/10ps

module forwardingUnit
    import exePkg::*;
(
    input  logic [RegAddrWidth-1:0] rs,
    input  logic [RegAddrWidth-1:0] rt,
    input  fwdSrc_t                 memFwd,
    input  fwdSrc_t                 wbFwd,
    output logic [1:0]              fwdA,
    output logic [1:0]              fwdB
);

    // True when a later stage writes the given source register
    function automatic logic hits(input fwdSrc_t src, input logic [RegAddrWidth-1:0] srcReg);
        return src.regWrite && (src.rd != '0) && (src.rd == srcReg);
    endfunction

    // MEM holds the newer value, so it is checked first
    function automatic logic [1:0] pick(input logic [RegAddrWidth-1:0] srcReg,
                                        input fwdSrc_t memSrc,
                                        input fwdSrc_t wbSrc);
        logic [1:0] sel;
        if (hits(memSrc, srcReg))
        begin
            sel = FwdMem;
        end
        else if (hits(wbSrc, srcReg))
        begin
            sel = FwdWb;
        end
        else
        begin
            sel = FwdReg;
        end
        return sel;
    endfunction

    assign fwdA = pick(rs, memFwd, wbFwd);
    assign fwdB = pick(rt, memFwd, wbFwd);

endmodule

//--- execute/execute.sv
`timescale 1ns/10ps

module execute
    import exePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    debugHold,
    input  idExCtrl_t               ctrl,
    input  logic [DataWidth-1:0]    pcPlus4,
    input  logic [DataWidth-1:0]    regA,
    input  logic [DataWidth-1:0]    regB,
    input  instrWord_t              immWord,
    input  logic [5:0]              immOpcode,
    input  logic [RegAddrWidth-1:0] rs,
    input  logic [RegAddrWidth-1:0] rt,
    input  logic [RegAddrWidth-1:0] rd,
    input  fwdSrc_t                 memFwd,
    input  fwdSrc_t                 wbFwd,
    output exMem_t                  exMem,
    output logic                    pcSel,
    output logic [DataWidth-1:0]    branchTarget
);

    logic [1:0]              fwdA;
    logic [1:0]              fwdB;
    logic [DataWidth-1:0]    rsVal;
    logic [DataWidth-1:0]    rtVal;
    logic [DataWidth-1:0]    shamtWord;
    logic [DataWidth-1:0]    opA;
    logic [DataWidth-1:0]    opB;
    logic [3:0]              aluSel;
    logic                    shiftOp;
    logic [DataWidth-1:0]    aluResult;
    logic                    aluZero;
    logic [RegAddrWidth-1:0] writeReg;
    exMem_t                  exMemNext;

    ////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////
    forwardingUnit fwdUnit (
        .rs     (rs),
        .rt     (rt),
        .memFwd (memFwd),
        .wbFwd  (wbFwd),
        .fwdA   (fwdA),
        .fwdB   (fwdB)
    );

    function automatic logic [DataWidth-1:0] fwdMux(input logic [1:0] sel,
                                                    input logic [DataWidth-1:0] regVal,
                                                    input logic [DataWidth-1:0] memVal,
                                                    input logic [DataWidth-1:0] wbVal);
        logic [DataWidth-1:0] val;
        case (sel)
            FwdMem:  val = memVal;
            FwdWb:   val = wbVal;
            default: val = regVal;
        endcase
        return val;
    endfunction

    assign rsVal = fwdMux(fwdA, regA, memFwd.data, wbFwd.data);
    assign rtVal = fwdMux(fwdB, regB, memFwd.data, wbFwd.data);

    ////////////////////////////////////////////////////////////
    // ALU and its operands
    ////////////////////////////////////////////////////////////
    aluControl aluCtl (
        .aluOp     (ctrl.exe.aluOp),
        .funct     (immWord.r.funct),
        .immOpcode (immOpcode),
        .aluSel    (aluSel),
        .shiftOp   (shiftOp)
    );

    assign shamtWord = {{(DataWidth-5){1'b0}}, immWord.r.shamt};

    // Shifts move rt to port A and put shamt on port B
    assign opA = shiftOp ? rtVal : rsVal;

    always_comb
    begin
        if (ctrl.exe.aluSrc)
        begin
            opB = immWord.imm;
        end
        else if (shiftOp)
        begin
            opB = shamtWord;
        end
        else
        begin
            opB = rtVal;
        end
    end

    alu aluCore (
        .a      (opA),
        .b      (opB),
        .aluSel (aluSel),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign writeReg = ctrl.exe.regDst ? rd : rt;

    // Branch compare uses the forwarded operands
    assign pcSel        = ctrl.mem.branch && (rsVal == rtVal);
    assign branchTarget = pcPlus4 + {immWord.imm[DataWidth-3:0], 2'b00};

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        exMemNext.wb        = ctrl.wb;
        exMemNext.mem       = ctrl.mem;
        exMemNext.aluResult = aluResult;
        exMemNext.zero      = aluZero;
        exMemNext.storeData = rtVal;
        exMemNext.writeReg  = writeReg;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exMem <= '0;
        end
        else if (!debugHold)
        begin
            exMem <= exMemNext;
        end
    end

endmodule

//--- dv/exeVectors.svh
`ifndef EXE_VECTORS_SVH
`define EXE_VECTORS_SVH

// Control words as {wb, mem, exe}
localparam idExCtrl_t CtrlR   = 9'b10_000_1100;
localparam idExCtrl_t CtrlI   = 9'b10_000_0111;
localparam idExCtrl_t CtrlLw  = 9'b11_010_0001;
localparam idExCtrl_t CtrlSw  = 9'b00_001_0001;
localparam idExCtrl_t CtrlBeq = 9'b00_100_0010;
localparam fwdSrc_t   NoFwd   = '0;

// Every row uses this PC+4, branch targets below assume it
localparam logic [DataWidth-1:0] Pc = 32'h100;

typedef struct {
    logic                    hold;
    idExCtrl_t               ctrl;
    logic [DataWidth-1:0]    regA, regB, imm;
    logic [5:0]              opcode;
    logic [RegAddrWidth-1:0] rs, rt, rd;
    fwdSrc_t                 memFwd, wbFwd;
    logic [DataWidth-1:0]    expResult, expStore;
    logic [RegAddrWidth-1:0] expReg;
    logic                    expPcSel;
    logic [DataWidth-1:0]    expTarget;
} vector_t;

vector_t vectors[$];

function automatic fwdSrc_t makeFwd(input logic [RegAddrWidth-1:0] d, input logic we,
                                    input logic [DataWidth-1:0] data);
    return '{d, we, data};
endfunction

task automatic addRow(input logic hd, input idExCtrl_t c,
                      input logic [DataWidth-1:0] a, b, im, input logic [5:0] op,
                      input logic [RegAddrWidth-1:0] s, t, d, input fwdSrc_t mf, wf,
                      input logic [DataWidth-1:0] res, st, input logic [RegAddrWidth-1:0] wr,
                      input logic sel, input logic [DataWidth-1:0] tgt);
    vectors.push_back('{hd, c, a, b, im, op, s, t, d, mf, wf, res, st, wr, sel, tgt});
endtask

// Columns: hold, ctrl, regA, regB, imm, opcode, rs, rt, rd, memFwd, wbFwd,
//          result, storeData, writeReg, pcSel, branchTarget
task automatic loadVectors();
    // R-type, imm carries {rd, shamt, funct}
    addRow(0, CtrlR, 5, 7, 'h1820, 0, 1, 2, 3, NoFwd, NoFwd, 12, 7, 3, 0, 'h6180);
    addRow(0, CtrlR, 9, 9, 'h1822, 0, 1, 2, 3, NoFwd, NoFwd, 0, 9, 3, 0, 'h6188);
    addRow(0, CtrlR, 'hF0F01234, 'hFF0FFFF, 'h1824, 0, 1, 2, 3, NoFwd, NoFwd,
           'hF01234, 'hFF0FFFF, 3, 0, 'h6190);
    addRow(0, CtrlR, 'hF0000000, 'hF, 'h1825, 0, 1, 2, 3, NoFwd, NoFwd,
           'hF000000F, 'hF, 3, 0, 'h6194);
    addRow(0, CtrlR, 'hFFFF0000, 'hF0F0F0F, 'h1826, 0, 1, 2, 3, NoFwd, NoFwd,
           'hF0F00F0F, 'hF0F0F0F, 3, 0, 'h6198);
    addRow(0, CtrlR, 'hFF, 'hFF00, 'h1827, 0, 1, 2, 3, NoFwd, NoFwd, 'hFFFF0000, 'hFF00, 3, 0,
           'h619C);
    addRow(0, CtrlR, -2, 1, 'h182A, 0, 1, 2, 3, NoFwd, NoFwd, 1, 1, 3, 0, 'h61A8);
    // Shifts by shamt, rs value is ignored
    addRow(0, CtrlR, 'hDEADBEEF, 3, 'h1900, 0, 1, 2, 3, NoFwd, NoFwd, 'h30, 3, 3, 0, 'h6500);
    addRow(0, CtrlR, 0, 'h80000000, 'h1FC2, 0, 1, 2, 3, NoFwd, NoFwd, 1, 'h80000000, 3, 0,
           'h8008);
    addRow(0, CtrlR, 0, 'h80000000, 'h1903, 0, 1, 2, 3, NoFwd, NoFwd, 'hF8000000, 'h80000000,
           3, 0, 'h650C);

    // I-type, loads and stores
    addRow(0, CtrlI, 10, 'h55, -3, 'h08, 1, 2, 3, NoFwd, NoFwd, 7, 'h55, 2, 0, 'hF4);
    addRow(0, CtrlI, -16, 0, -8, 'h0A, 1, 2, 3, NoFwd, NoFwd, 1, 0, 2, 0, 'hE0);
    addRow(0, CtrlI, 'h12345678, 0, 'hFF, 'h0C, 1, 2, 3, NoFwd, NoFwd, 'h78, 0, 2, 0, 'h4FC);
    addRow(0, CtrlI, 'h12340000, 0, 'h5678, 'h0D, 1, 2, 3, NoFwd, NoFwd, 'h12345678, 0, 2, 0,
           'h15AE0);
    addRow(0, CtrlI, 'hFFFF, 0, 'hF0F, 'h0E, 1, 2, 3, NoFwd, NoFwd, 'hF0F0, 0, 2, 0, 'h3D3C);
    addRow(0, CtrlI, 'h11111111, 0, 'hFFFFABCD, 'h0F, 1, 2, 3, NoFwd, NoFwd, 'hABCD0000, 0,
           2, 0, 'hFFFEB034);
    addRow(0, CtrlLw, 'h10000000, 'h77, 'h10, 'h23, 1, 2, 0, NoFwd, NoFwd, 'h10000010, 'h77,
           2, 0, 'h140);
    addRow(0, CtrlSw, 'h10000000, 'hCAFEF00D, -4, 'h2B, 1, 2, 0, NoFwd, NoFwd, 'hFFFFFFC,
           'hCAFEF00D, 2, 0, 'hF0);

    // Forwarding
    addRow(0, CtrlR, 1, 2, 'h1820, 0, 1, 2, 3, NoFwd, makeFwd(2, 1, 'h200), 'h201, 'h200, 3, 0,
           'h6180);
    addRow(0, CtrlR, 1, 2, 'h1820, 0, 1, 2, 3, makeFwd(1, 1, 'h1000), makeFwd(1, 1, 'h2000),
           'h1002, 2, 3, 0, 'h6180);
    addRow(0, CtrlR, 1, 2, 'h1820, 0, 1, 2, 3, makeFwd(2, 0, 'h300), NoFwd, 3, 2, 3, 0, 'h6180);
    addRow(0, CtrlR, 0, 2, 'h1820, 0, 0, 2, 3, makeFwd(0, 1, 'h400), makeFwd(0, 1, 'h500),
           2, 2, 3, 0, 'h6180);
    addRow(0, CtrlR, 1, 2, 'h1820, 0, 1, 2, 3, makeFwd(1, 1, 'h100), NoFwd, 'h102, 2, 3, 0,
           'h6180);

    // Hold, register keeps the row above
    addRow(1, CtrlR, 1, 1, 'h1820, 0, 1, 2, 3, NoFwd, NoFwd, 0, 0, 0, 0, 'h6180);

    // Branches
    addRow(0, CtrlBeq, 'h44, 'h44, 4, 'h04, 1, 2, 0, NoFwd, NoFwd, 0, 'h44, 2, 1, 'h110);
    addRow(0, CtrlBeq, 'h44, 'h45, -2, 'h04, 1, 2, 0, NoFwd, NoFwd, 'hFFFFFFFF, 'h45, 2, 0,
           'hF8);
    addRow(0, CtrlBeq, 'h10, 'h99, -16, 'h04, 1, 2, 0, makeFwd(2, 1, 'h10), NoFwd, 0, 'h10,
           2, 1, 'hC0);
endtask

`endif

//--- dv/tbExecute.sv
`timescale 1ns/10ps

module tbExecute
    import exePkg::*;
();

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 5;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    debugHold;
    idExCtrl_t               ctrl;
    logic [DataWidth-1:0]    pcPlus4;
    logic [DataWidth-1:0]    regA;
    logic [DataWidth-1:0]    regB;
    instrWord_t              immWord;
    logic [5:0]              immOpcode;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [RegAddrWidth-1:0] rd;
    fwdSrc_t                 memFwd;
    fwdSrc_t                 wbFwd;
    exMem_t                  exMem;
    logic                    pcSel;
    logic [DataWidth-1:0]    branchTarget;

    `include "exeVectors.svh"

    execute DUT (
        .clk          (clk),
        .rst          (rst),
        .debugHold    (debugHold),
        .ctrl         (ctrl),
        .pcPlus4      (pcPlus4),
        .regA         (regA),
        .regB         (regB),
        .immWord      (immWord),
        .immOpcode    (immOpcode),
        .rs           (rs),
        .rt           (rt),
        .rd           (rd),
        .memFwd       (memFwd),
        .wbFwd        (wbFwd),
        .exMem        (exMem),
        .pcSel        (pcSel),
        .branchTarget (branchTarget)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic stopRun();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [74:0] expected,
                              input logic [74:0] actual);
        assert (actual === expected)
        else
        begin
            $display("** Error at %0d ns: %s expected 'h%0h, got 'h%0h",
                     $time, name, expected, actual);
            stopRun();
        end
    endtask

    task automatic applyRow(input vector_t v);
        debugHold = v.hold;
        ctrl      = v.ctrl;
        pcPlus4   = Pc;
        regA      = v.regA;
        regB      = v.regB;
        immWord   = v.imm;
        immOpcode = v.opcode;
        rs        = v.rs;
        rt        = v.rt;
        rd        = v.rd;
        memFwd    = v.memFwd;
        wbFwd     = v.wbFwd;
    endtask

    // Register contents the row should leave behind
    function automatic exMem_t expectedExMem(input vector_t v);
        exMem_t e;
        e.wb        = v.ctrl.wb;
        e.mem       = v.ctrl.mem;
        e.aluResult = v.expResult;
        e.zero      = (v.expResult == '0);
        e.storeData = v.expStore;
        e.writeReg  = v.expReg;
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        exMem_t expMem;
        rst = 1'b1;
        applyRow('{default: '0});
        loadVectors();
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue("exMem", '0, exMem);
        expMem = '0;
        foreach (vectors[i])
        begin
            applyRow(vectors[i]);
            @(negedge clk);
            checkValue("pcSel", vectors[i].expPcSel, pcSel);
            checkValue("branchTarget", vectors[i].expTarget, branchTarget);
            if (!vectors[i].hold)
            begin
                expMem = expectedExMem(vectors[i]);
            end
            @(posedge clk);
            #1;
            checkValue("exMem", expMem, exMem);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Watchdog, sized from the table once it is loaded
    initial
    begin
        int limit;
        #1;
        limit = (vectors.size() + ResetCycles + 10) * ClkPeriod;
        #(limit);
        $display("Watchdog expired after %0d ns before the vector table finished", limit);
        stopRun();
    end

endmodule

//--- sim.f
+incdir+dv
common/exePkg.sv
rtl/alu.sv
rtl/aluControl.sv
rtl/forwardingUnit.sv
execute/execute.sv
dv/tbExecute.sv

//--- Bender.yml
package:
  name: execute

sources:
  - files:
      - common/exePkg.sv
      - rtl/alu.sv
      - rtl/aluControl.sv
      - rtl/forwardingUnit.sv
      - execute/execute.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tbExecute.sv
